//--- hdl/dcu_wbf_pkg.sv
// write buffer package: line geometry, byte mask type and the two-view line union.
package dcu_wbf_pkg;

    localparam int DCU_DATA_WIDTH = 32;
    localparam int LINE_BYTES = 64;
    localparam int LINE_ADDR_W = 26; // byte address bits 31:6.
    localparam int CHUNK_W = 128;
    localparam int LINE_W = LINE_BYTES * 8;

    typedef logic [LINE_BYTES-1:0] wbf_mask_t;

    // writes see 128-bit chunks, reads and the drain see 32-bit words.
    typedef union packed {
        logic [LINE_W/CHUNK_W-1:0][CHUNK_W-1:0] chunk;
        logic [LINE_W/DCU_DATA_WIDTH-1:0][DCU_DATA_WIDTH-1:0] word;
    } wbf_line_u;

endpackage

//--- hdl/wbf_write_if.sv
// write buffer interfaces: one chunk write port, and the buffer to drain link.
`timescale 1ns/1ps

interface wbf_write_if #(
    parameter int WBF_DEPTH = 3
);
    import dcu_wbf_pkg::*;

    logic                   valid;
    logic [WBF_DEPTH-1:0]   index; // one-hot entry.
    logic [5:4]             addr;  // chunk within the line.
    logic [CHUNK_W-1:0]     data;
    logic [CHUNK_W/8-1:0]   mask;

    modport source (output valid, index, addr, data, mask);
    modport sink (input valid, index, addr, data, mask);

endinterface

// selected entry view for the drain, plus its one-hot dequeue.
interface wbf_drain_if #(
    parameter int WBF_DEPTH = 3
);
    import dcu_wbf_pkg::*;

    logic [WBF_DEPTH-1:0]   committed;
    logic [WBF_DEPTH-1:0]   sel;
    logic [LINE_ADDR_W-1:0] line;
    wbf_line_u              data;
    wbf_mask_t              mask;
    logic [WBF_DEPTH-1:0]   deq;

    modport buffer (output committed, line, data, mask, input sel, deq);
    modport drain (input committed, line, data, mask, output sel, deq);

endinterface

//--- hdl/dcu_wbf_ent.sv
// write buffer entry holding one line of store data, its byte mask and state.
`timescale 1ns/1ps

module dcu_wbf_ent (
    input  logic                                   dcu_clk,
    input  logic                                   rst,
    input  logic                                   enq,
    input  logic [dcu_wbf_pkg::LINE_ADDR_W-1:0]    line_in,
    input  logic                                   commit,
    input  logic                                   deq,
    input  logic                                   we,
    input  logic [5:4]                             waddr,
    input  logic [dcu_wbf_pkg::CHUNK_W-1:0]        wdata,
    input  logic [dcu_wbf_pkg::CHUNK_W/8-1:0]      wmask,
    output logic                                   valid,
    output logic                                   committed,
    output logic [dcu_wbf_pkg::LINE_ADDR_W-1:0]    line,
    output dcu_wbf_pkg::wbf_line_u                 data,
    output dcu_wbf_pkg::wbf_mask_t                 mask
);
    import dcu_wbf_pkg::*;

    always_ff @(posedge dcu_clk) begin
        if (rst) begin
            valid <= 1'b0;
            committed <= 1'b0;
        end else if (enq) begin
            valid <= 1'b1;
            committed <= 1'b0;
        end else if (deq) begin
            valid <= 1'b0;
            committed <= 1'b0;
        end else if (commit && valid) begin
            committed <= 1'b1;
        end
    end

    always_ff @(posedge dcu_clk) begin
        if (enq) begin
            line <= line_in;
            mask <= '0; // a fresh line holds no bytes yet.
        end else if (we) begin
            for (int b = 0; b < CHUNK_W / 8; b++) begin
                if (wmask[b]) begin
                    data.chunk[waddr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
            mask[{waddr, 4'b0000} +: CHUNK_W/8] <= mask[{waddr, 4'b0000} +: CHUNK_W/8] | wmask;
        end
    end

    // the store path must only touch entries it was granted.
    ent_write_valid: assert property (
        @(posedge dcu_clk) disable iff (rst) (we || commit) |-> valid
    ) else $error("write buffer entry written or committed while invalid.");

endmodule

//--- hdl/dcu_wbf_alloc.sv
// allocation arbiter giving port 0 priority over port 1 and granting the lowest free entry.
`timescale 1ns/1ps

module dcu_wbf_alloc #(
    parameter int WBF_DEPTH = 3
) (
    input  logic                   a0_valid,
    input  logic                   a0_kill,
    input  logic                   a1_valid,
    input  logic [WBF_DEPTH-1:0]   free,
    output logic                   a0_ready,
    output logic                   a1_ready,
    output logic [WBF_DEPTH-1:0]   enq,
    output logic                   enq_take,
    output logic                   enq_port
);

    logic       any_free;
    logic [1:0] grant;

    assign any_free = |free;
    assign grant[0] = a0_valid;
    assign grant[1] = a1_valid & ~a0_valid; // port 1 waits behind port 0.

    assign a0_ready = grant[0] & any_free;
    assign a1_ready = grant[1] & any_free;

    assign enq = free & (~free + 1'b1); // isolate lowest free bit.

    // a killed port 0 request completes its handshake but keeps the entry free.
    assign enq_take = (a0_ready & ~a0_kill) | a1_ready;
    assign enq_port = grant[1];

endmodule

//--- hdl/dcu_wbf.sv
// data cache write buffer: entry array, write steering, load forwarding and drain view.
`timescale 1ns/1ps

module dcu_wbf #(
    parameter int WBF_DEPTH = 3
) (
    input  logic                                       dcu_clk,
    input  logic                                       rst,
    input  logic                                       a0_valid,
    input  logic                                       a0_kill,
    input  logic [dcu_wbf_pkg::LINE_ADDR_W-1:0]        a0_line,
    input  logic                                       a1_valid,
    input  logic [dcu_wbf_pkg::LINE_ADDR_W-1:0]        a1_line,
    output logic                                       a0_ready,
    output logic                                       a1_ready,
    output logic [WBF_DEPTH-1:0]                       a_index,
    wbf_write_if.sink                                  w0,
    wbf_write_if.sink                                  w1,
    input  logic [WBF_DEPTH-1:0]                       r0_index,
    input  logic [5:2]                                 r0_addr,
    input  logic [WBF_DEPTH-1:0]                       r1_index,
    input  logic [5:2]                                 r1_addr,
    output logic [dcu_wbf_pkg::DCU_DATA_WIDTH-1:0]     r0_data,
    output logic [dcu_wbf_pkg::DCU_DATA_WIDTH-1:0]     r1_data,
    output logic [dcu_wbf_pkg::DCU_DATA_WIDTH/8-1:0]   r1_mask,
    input  logic                                       commit_valid,
    input  logic [WBF_DEPTH-1:0]                       commit_index,
    output logic [WBF_DEPTH-1:0]                       busy,
    wbf_drain_if.buffer                                dr
);
    import dcu_wbf_pkg::*;

    logic [WBF_DEPTH-1:0]   ent_valid;
    logic [WBF_DEPTH-1:0]   ent_committed;
    logic [LINE_ADDR_W-1:0] ent_line [WBF_DEPTH];
    wbf_line_u              ent_data [WBF_DEPTH];
    wbf_mask_t              ent_mask [WBF_DEPTH];
    logic [WBF_DEPTH-1:0]   enq;
    logic                   enq_take;
    logic                   enq_port;
    logic [LINE_ADDR_W-1:0] line_in;
    wbf_line_u              r0_line;
    wbf_line_u              r1_line;
    wbf_mask_t              r1_lmask;

    dcu_wbf_alloc #(
        .WBF_DEPTH(WBF_DEPTH)
    ) u_alloc (
        .a0_valid(a0_valid),
        .a0_kill(a0_kill),
        .a1_valid(a1_valid),
        .free(~ent_valid),
        .a0_ready(a0_ready),
        .a1_ready(a1_ready),
        .enq(enq),
        .enq_take(enq_take),
        .enq_port(enq_port)
    );

    assign a_index = enq;
    assign line_in = enq_port ? a1_line : a0_line;
    assign busy = ent_valid;

    for (genvar i = 0; i < WBF_DEPTH; i++) begin : gen_ent
        logic w0_sel;
        logic w1_sel;

        assign w0_sel = w0.valid & w0.index[i];
        assign w1_sel = w1.valid & w1.index[i];

        dcu_wbf_ent u_ent (
            .dcu_clk(dcu_clk),
            .rst(rst),
            .enq(enq[i] & enq_take),
            .line_in(line_in),
            .commit(commit_valid & commit_index[i]),
            .deq(dr.deq[i]),
            .we(w0_sel | w1_sel),
            .waddr(w1_sel ? w1.addr : w0.addr),
            .wdata(w1_sel ? w1.data : w0.data),
            .wmask(w1_sel ? w1.mask : w0.mask),
            .valid(ent_valid[i]),
            .committed(ent_committed[i]),
            .line(ent_line[i]),
            .data(ent_data[i]),
            .mask(ent_mask[i])
        );

        // store and merge paths never target one entry together.
        write_excl: assert property (
            @(posedge dcu_clk) disable iff (rst) !(w0_sel && w1_sel)
        ) else $error("both write ports select entry %0d.", i);
    end

    // one-hot line muxes for both load ports and the drain.
    always_comb begin
        r0_line = '0;
        r1_line = '0;
        r1_lmask = '0;
        dr.line = '0;
        dr.data = '0;
        dr.mask = '0;
        for (int i = 0; i < WBF_DEPTH; i++) begin
            if (r0_index[i]) begin
                r0_line = r0_line | ent_data[i];
            end
            if (r1_index[i]) begin
                r1_line = r1_line | ent_data[i];
                r1_lmask = r1_lmask | ent_mask[i];
            end
            if (dr.sel[i]) begin
                dr.line = dr.line | ent_line[i];
                dr.data = dr.data | ent_data[i];
                dr.mask = dr.mask | ent_mask[i];
            end
        end
    end

    assign r0_data = r0_line.word[r0_addr];
    assign r1_data = r1_line.word[r1_addr];
    assign r1_mask = r1_lmask[{r1_addr, 2'b00} +: DCU_DATA_WIDTH/8];
    assign dr.committed = ent_committed;

endmodule

//--- hdl/dcu_wbf_drain.sv
// drain unit, writes committed lines out word by word over AXI4-Lite.
`timescale 1ns/1ps

module dcu_wbf_drain #(
    parameter int WBF_DEPTH = 3
) (
    input  logic                                       dcu_clk,
    input  logic                                       rst,
    wbf_drain_if.drain                                 dr,
    output logic [dcu_wbf_pkg::DCU_DATA_WIDTH-1:0]     awaddr,
    output logic                                       awvalid,
    input  logic                                       awready,
    output logic [dcu_wbf_pkg::DCU_DATA_WIDTH-1:0]     wdata,
    output logic [dcu_wbf_pkg::DCU_DATA_WIDTH/8-1:0]   wstrb,
    output logic                                       wvalid,
    input  logic                                       wready,
    input  logic                                       bvalid,
    input  logic [1:0]                                 bresp,
    output logic                                       bready
);
    import dcu_wbf_pkg::*;

    localparam int WORDS = LINE_BYTES * 8 / DCU_DATA_WIDTH;
    localparam int WSTRB_W = DCU_DATA_WIDTH / 8;

    typedef enum logic [1:0] {IDLE, ADDR, RESP, DEQ} state_t;

    state_t               state;
    logic [WBF_DEPTH-1:0] sel_q;
    logic [3:0]           cnt;
    logic [WORDS-1:0]     word_any;
    logic [4:0]           from_start; // {found, word}.
    logic [4:0]           from_next;
    logic                 aw_done;
    logic                 w_done;

    // first word at or after start that has any byte to write.
    function automatic logic [4:0] next_word(input logic [WORDS-1:0] any, input logic [4:0] start);
        logic [4:0] res;
        res = '0;
        for (int i = WORDS - 1; i >= 0; i--) begin
            if (any[i] && i >= start) begin
                res = {1'b1, 4'(i)};
            end
        end
        return res;
    endfunction

    always_comb begin
        for (int w = 0; w < WORDS; w++) begin
            word_any[w] = |dr.mask[w*WSTRB_W +: WSTRB_W];
        end
    end

    assign from_start = next_word(word_any, 5'd0);
    assign from_next = next_word(word_any, {1'b0, cnt} + 5'd1);

    // lowest committed entry while idle, then held.
    assign dr.sel = (state == IDLE) ? (dr.committed & (~dr.committed + 1'b1)) : sel_q;
    assign dr.deq = (state == DEQ) ? sel_q : '0;

    assign awaddr = {dr.line, cnt, 2'b00};
    assign wdata = dr.data.word[cnt];
    assign wstrb = dr.mask[{cnt, 2'b00} +: WSTRB_W];
    assign bready = (state == RESP);
    assign aw_done = !awvalid || awready;
    assign w_done = !wvalid || wready;

    always_ff @(posedge dcu_clk) begin
        if (rst) begin
            state <= IDLE;
            sel_q <= '0;
            cnt <= '0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
        end else begin
            case (state)
                IDLE: if (|dr.committed) begin
                    sel_q <= dr.sel;
                    if (from_start[4]) begin
                        cnt <= from_start[3:0];
                        awvalid <= 1'b1;
                        wvalid <= 1'b1;
                        state <= ADDR;
                    end else begin
                        state <= DEQ; // nothing to write.
                    end
                end
                ADDR: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if (aw_done && w_done) state <= RESP;
                end
                RESP: if (bvalid) begin
                    if (from_next[4]) begin
                        cnt <= from_next[3:0];
                        awvalid <= 1'b1;
                        wvalid <= 1'b1;
                        state <= ADDR;
                    end else begin
                        state <= DEQ;
                    end
                end
                DEQ: state <= IDLE;
            endcase
        end
    end

    aw_hold: assert property (
        @(posedge dcu_clk) disable iff (rst) awvalid && !awready |=> awvalid && $stable(awaddr)
    ) else $error("awvalid or awaddr changed before awready.");

    bresp_known: assert property (
        @(posedge dcu_clk) disable iff (rst) bvalid && bready |-> !$isunknown(bresp)
    ) else $error("write response carries unknown bresp.");

endmodule

//--- hdl/dcu_wbf_top.sv
// data cache write buffer with its AXI4-Lite drain.
`timescale 1ns/1ps

module dcu_wbf_top #(
    parameter int WBF_DEPTH = 3
) (
    input  logic                                       dcu_clk,
    input  logic                                       rst,
    input  logic                                       a0_valid,
    input  logic                                       a0_kill,
    input  logic [dcu_wbf_pkg::LINE_ADDR_W-1:0]        a0_line,
    input  logic                                       a1_valid,
    input  logic [dcu_wbf_pkg::LINE_ADDR_W-1:0]        a1_line,
    output logic                                       a0_ready,
    output logic                                       a1_ready,
    output logic [WBF_DEPTH-1:0]                       a_index,
    input  logic                                       w0_valid,
    input  logic [WBF_DEPTH-1:0]                       w0_index,
    input  logic [5:4]                                 w0_addr,
    input  logic [dcu_wbf_pkg::CHUNK_W-1:0]            w0_data,
    input  logic                                       w1_valid,
    input  logic [WBF_DEPTH-1:0]                       w1_index,
    input  logic [5:4]                                 w1_addr,
    input  logic [dcu_wbf_pkg::CHUNK_W-1:0]            w1_data,
    input  logic [dcu_wbf_pkg::CHUNK_W/8-1:0]          w1_mask,
    input  logic [WBF_DEPTH-1:0]                       r0_index,
    input  logic [5:2]                                 r0_addr,
    input  logic [WBF_DEPTH-1:0]                       r1_index,
    input  logic [5:2]                                 r1_addr,
    output logic [dcu_wbf_pkg::DCU_DATA_WIDTH-1:0]     r0_data,
    output logic [dcu_wbf_pkg::DCU_DATA_WIDTH-1:0]     r1_data,
    output logic [dcu_wbf_pkg::DCU_DATA_WIDTH/8-1:0]   r1_mask,
    input  logic                                       commit_valid,
    input  logic [WBF_DEPTH-1:0]                       commit_index,
    output logic [WBF_DEPTH-1:0]                       busy,
    output logic [dcu_wbf_pkg::DCU_DATA_WIDTH-1:0]     awaddr,
    output logic                                       awvalid,
    input  logic                                       awready,
    output logic [dcu_wbf_pkg::DCU_DATA_WIDTH-1:0]     wdata,
    output logic [dcu_wbf_pkg::DCU_DATA_WIDTH/8-1:0]   wstrb,
    output logic                                       wvalid,
    input  logic                                       wready,
    input  logic                                       bvalid,
    input  logic [1:0]                                 bresp,
    output logic                                       bready
);

    wbf_write_if #(.WBF_DEPTH(WBF_DEPTH)) w0_if ();
    wbf_write_if #(.WBF_DEPTH(WBF_DEPTH)) w1_if ();
    wbf_drain_if #(.WBF_DEPTH(WBF_DEPTH)) dr_if ();

    assign w0_if.valid = w0_valid;
    assign w0_if.index = w0_index;
    assign w0_if.addr = w0_addr;
    assign w0_if.data = w0_data;
    assign w0_if.mask = '1; // store path always writes whole chunks.

    assign w1_if.valid = w1_valid;
    assign w1_if.index = w1_index;
    assign w1_if.addr = w1_addr;
    assign w1_if.data = w1_data;
    assign w1_if.mask = w1_mask;

    dcu_wbf #(
        .WBF_DEPTH(WBF_DEPTH)
    ) u_wbf (
        .*,
        .w0(w0_if),
        .w1(w1_if),
        .dr(dr_if)
    );

    dcu_wbf_drain #(
        .WBF_DEPTH(WBF_DEPTH)
    ) u_drain (
        .*,
        .dr(dr_if)
    );

endmodule

//--- test/tb_dcu_wbf.sv
// testbench for the data cache write buffer, with an AXI4-Lite slave model and a line model.
`timescale 1ns/1ps

module tb_dcu_wbf;

    localparam int DEPTH = 3;
    localparam logic [31:0] SEED = 32'h06b6_e31a;
    // four drains of up to 16 words at a few stalled cycles each, plus setup, with wide margin.
    localparam int MAX_CYCLES = 4000;

    logic dcu_clk = 1'b0;
    logic rst;
    logic a0_valid, a0_kill, a1_valid, a0_ready, a1_ready;
    logic [25:0] a0_line, a1_line;
    logic [DEPTH-1:0] a_index, w0_index, w1_index, r0_index, r1_index;
    logic [DEPTH-1:0] commit_index, busy;
    logic w0_valid, w1_valid, commit_valid;
    logic [5:4] w0_addr, w1_addr;
    logic [127:0] w0_data, w1_data;
    logic [15:0] w1_mask;
    logic [5:2] r0_addr, r1_addr;
    logic [31:0] r0_data, r1_data, awaddr, wdata;
    logic [3:0] r1_mask, wstrb;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic [1:0] bresp;

    integer bp_seed = SEED;
    integer data_seed = ~SEED;
    int errors = 0;
    int cycles = 0;
    int writes_seen = 0;

    // line model per entry, and writes as {addr, data, strb}.
    logic [25:0] m_line [DEPTH];
    logic [511:0] m_data [DEPTH];
    logic [63:0] m_mask [DEPTH];
    logic [67:0] exp_q [$];
    logic [67:0] got_q [$];
    logic [67:0] got_w, want_w;
    logic [31:0] bp_rnd, cap_addr, cap_data;
    logic [3:0] cap_strb;
    logic aw_seen, w_seen, resp_due;

    dcu_wbf_top #(.WBF_DEPTH(DEPTH)) uut (.*);

    always #4 dcu_clk = ~dcu_clk;

    task automatic check_value(input string name, input logic [67:0] expected,
                               input logic [67:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    function automatic logic [DEPTH-1:0] onehot(input int e);
        return DEPTH'(1 << e);
    endfunction

    function automatic logic [127:0] rand_chunk();
        return {$random(data_seed), $random(data_seed), $random(data_seed), $random(data_seed)};
    endfunction

    function automatic void model_alloc(input int e, input logic [25:0] line);
        m_line[e] = line;
        m_mask[e] = '0; // old data stays, only the mask restarts.
    endfunction

    function automatic void model_write(input int port, input int e, input int c,
                                        input logic [127:0] data, input logic [15:0] mask);
        for (int b = 0; b < 16; b++) begin
            if (port == 0 || mask[b]) begin
                m_data[e][(c*16 + b)*8 +: 8] = data[b*8 +: 8];
                m_mask[e][c*16 + b] = 1'b1;
            end
        end
    endfunction

    // one write per word with any valid byte, lowest word first.
    function automatic void expected_writes(input int e);
        for (int w = 0; w < 16; w++) begin
            if (m_mask[e][w*4 +: 4] != 4'h0) begin
                exp_q.push_back({m_line[e], 4'(w), 2'b00, m_data[e][w*32 +: 32],
                                 m_mask[e][w*4 +: 4]});
            end
        end
    endfunction

    task automatic allocate(input int port, input logic kill, input logic [25:0] line,
                            input int exp_e, input string name);
        logic got;
        got = 1'b0;
        if (port == 0) begin
            a0_valid <= 1'b1;
            a0_kill <= kill;
            a0_line <= line;
        end else begin
            a1_valid <= 1'b1;
            a1_line <= line;
        end
        while (!got) begin
            @(posedge dcu_clk);
            got = (port == 0) ? a0_ready : a1_ready;
        end
        check_value(name, onehot(exp_e), a_index);
        a0_valid <= 1'b0;
        a0_kill <= 1'b0;
        a1_valid <= 1'b0;
        if (!kill) model_alloc(exp_e, line);
    endtask

    task automatic write_chunk(input int port, input int e, input int c,
                               input logic [127:0] data, input logic [15:0] mask);
        if (port == 0) begin
            w0_valid <= 1'b1;
            w0_index <= onehot(e);
            w0_addr <= 2'(c);
            w0_data <= data;
        end else begin
            w1_valid <= 1'b1;
            w1_index <= onehot(e);
            w1_addr <= 2'(c);
            w1_data <= data;
            w1_mask <= mask;
        end
        @(posedge dcu_clk);
        w0_valid <= 1'b0;
        w1_valid <= 1'b0;
        model_write(port, e, c, data, mask);
    endtask

    // r0 walks the words upward and r1 downward.
    task automatic check_reads(input int e);
        for (int w = 0; w < 16; w++) begin
            r0_index <= onehot(e);
            r0_addr <= 4'(w);
            r1_index <= onehot(e);
            r1_addr <= 4'(15 - w);
            @(posedge dcu_clk);
            check_value("read r0_data", m_data[e][w*32 +: 32], r0_data);
            check_value("read r1_data", m_data[e][(15 - w)*32 +: 32], r1_data);
            check_value("read r1_mask", m_mask[e][(15 - w)*4 +: 4], r1_mask);
        end
    endtask

    task automatic drain_entry(input int e, input string name);
        int seen_before;
        int n_exp;
        seen_before = writes_seen;
        expected_writes(e);
        n_exp = exp_q.size();
        commit_valid <= 1'b1;
        commit_index <= onehot(e);
        @(posedge dcu_clk);
        commit_valid <= 1'b0;
        @(posedge dcu_clk);
        while (busy[e] !== 1'b0) @(posedge dcu_clk);
        check_value({name, " writes left"}, 0, exp_q.size());
        check_value({name, " write count"}, seen_before + n_exp, writes_seen);
    endtask

    // AXI4-Lite slave with random ready and response delays.
    always @(posedge dcu_clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            aw_seen = 1'b0;
            w_seen = 1'b0;
            resp_due = 1'b0;
        end else begin
            bp_rnd = $random(bp_seed);
            if (bvalid && bready) resp_due = 1'b0;
            if (awvalid && awready) begin
                aw_seen = 1'b1;
                cap_addr = awaddr;
            end
            if (wvalid && wready) begin
                w_seen = 1'b1;
                cap_data = wdata;
                cap_strb = wstrb;
            end
            if (aw_seen && w_seen) begin
                got_q.push_back({cap_addr, cap_data, cap_strb});
                writes_seen++;
                aw_seen = 1'b0;
                w_seen = 1'b0;
                resp_due = 1'b1;
            end
            awready <= bp_rnd[0];
            wready <= bp_rnd[1];
            bvalid <= resp_due && (bvalid || bp_rnd[2]); // held until bready.
        end
    end

    always @(posedge dcu_clk) begin
        if (got_q.size() != 0) begin
            got_w = got_q.pop_front();
            if (exp_q.size() == 0) begin
                errors++;
                $display("drain wrote to %h when no write was expected", got_w[67:36]);
            end else begin
                want_w = exp_q.pop_front();
                check_value("drain awaddr", want_w[67:36], got_w[67:36]);
                check_value("drain wdata", want_w[35:4], got_w[35:4]);
                check_value("drain wstrb", want_w[3:0], got_w[3:0]);
            end
        end
    end

    always @(posedge dcu_clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        {a0_valid, a0_kill, a1_valid, w0_valid, w1_valid, commit_valid} = '0;
        {a0_line, a1_line, w0_index, w1_index, w0_addr, w1_addr} = '0;
        {w0_data, w1_data, w1_mask, r0_index, r1_index, r0_addr, r1_addr} = '0;
        {commit_index, awready, wready, bvalid, bresp} = '0;
        for (int e = 0; e < DEPTH; e++) begin
            m_data[e] = 'x;
            model_alloc(e, '0);
        end
        repeat (5) @(posedge dcu_clk);
        check_value("reset busy", 0, busy);
        check_value("reset ready", 0, {a0_ready, a1_ready});
        check_value("reset axi", 0, {awvalid, wvalid, bready});
        rst <= 1'b0;
        @(posedge dcu_clk);

        // killed request takes no entry.
        allocate(0, 1'b1, 26'h2aa_0001, 0, "kill index");
        @(posedge dcu_clk);
        check_value("kill busy", 0, busy);
        allocate(0, 1'b0, 26'h012_3456, 0, "alloc index 0");

        // port 0 wins, port 1 gets the next entry.
        a0_valid <= 1'b1;
        a0_line <= 26'h155_0002;
        a1_valid <= 1'b1;
        a1_line <= 26'h0f0_0f03;
        @(posedge dcu_clk);
        check_value("prio a0_ready", 1, a0_ready);
        check_value("prio a1_ready", 0, a1_ready);
        check_value("prio index", 3'b010, a_index);
        a0_valid <= 1'b0;
        model_alloc(1, 26'h155_0002);
        @(posedge dcu_clk);
        check_value("prio a1 retry", 1, a1_ready);
        check_value("prio a1 index", 3'b100, a_index);
        a1_valid <= 1'b0;
        model_alloc(2, 26'h0f0_0f03);
        a0_valid <= 1'b1;
        a1_valid <= 1'b1;
        repeat (4) begin
            @(posedge dcu_clk);
            check_value("full ready", 0, {a0_ready, a1_ready});
        end
        a0_valid <= 1'b0;
        a1_valid <= 1'b0;

        write_chunk(0, 0, 0, rand_chunk(), '1);
        write_chunk(0, 0, 3, rand_chunk(), '1);
        write_chunk(1, 0, 3, rand_chunk(), 16'($random(data_seed)));
        write_chunk(1, 0, 1, rand_chunk(), 16'h00f0);
        write_chunk(1, 1, 2, rand_chunk(), 16'($random(data_seed)));
        write_chunk(1, 1, 0, rand_chunk(), 16'h8001);
        check_reads(0);
        check_reads(1);

        // entry 0 drains while port 0 keeps asking for a slot.
        a0_valid <= 1'b1;
        a0_line <= 26'h3c3_c3c4;
        drain_entry(0, "drain entry 0");
        check_value("freed ready", 1, a0_ready);
        check_value("freed index", 3'b001, a_index);
        a0_valid <= 1'b0;
        model_alloc(0, 26'h3c3_c3c4);
        @(posedge dcu_clk);
        check_value("freed busy", 3'b111, busy);

        write_chunk(1, 0, 2, rand_chunk(), 16'($random(data_seed)));
        check_reads(0);
        drain_entry(2, "drain empty entry 2");
        drain_entry(1, "drain entry 1");
        drain_entry(0, "drain entry 0 again");
        @(posedge dcu_clk);
        check_value("final busy", 0, busy);
        check_value("final queues", 0, exp_q.size() + got_q.size());

        $display("errors: %0d, axi writes: %0d, cycles: %0d", errors, writes_seen, cycles);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/dcu_wbf_pkg.sv
hdl/wbf_write_if.sv
hdl/dcu_wbf_ent.sv
hdl/dcu_wbf_alloc.sv
hdl/dcu_wbf.sv
hdl/dcu_wbf_drain.sv
hdl/dcu_wbf_top.sv
test/tb_dcu_wbf.sv
